// ==== hdl/cache_types_pkg.sv ====
// cache data types
// address, word and line widths and the line geometry
package cache_types_pkg;

	localparam int ADDR_BITS    = 32;
	localparam int WORD_BITS    = 32;
	localparam int LINE_BITS    = 64; // two words per line
	localparam int OFFSET_BITS  = 3;  // byte offset inside a line
	localparam int WORD_SEL_BIT = 2;  // address bit picking the word in a line

	typedef logic [ADDR_BITS-1:0] addr_t; // cpu byte address
	typedef logic [WORD_BITS-1:0] word_t; // cpu data word
	typedef logic [LINE_BITS-1:0] line_t; // cache line, memory transfer unit

endpackage : cache_types_pkg

// ==== hdl/cache_ctrl_pkg.sv ====
// cache controller definitions
package cache_ctrl_pkg;

	typedef enum logic [2:0] {
		s_idle,            // nothing in service
		s_write_back,      // dirty victim goes out to memory
		s_load_from_mem,   // fetch requested line
		s_load_into_cache, // fetched line into the victim way
		s_respond          // answer the cpu, lru and write data update
	} ctrl_state_e;

	typedef logic way_t; // way index, 0 or 1

endpackage : cache_ctrl_pkg

// ==== hdl/cache_ctrl_if.sv ====
// command and status bundle between cache controller and datapath
`timescale 1ns/1ps

interface cache_ctrl_if;
	import cache_ctrl_pkg::*;

	// controller commands
	way_t way_sel;      // way to access
	logic load_cache;   // write line of selected way
	logic source_sel;   // 0 cpu write merge, 1 memory
	logic load_dirty;   // write dirty bit of selected way
	logic load_lru;     // update lru bit of the set
	logic wb_addr_sel;  // 1 victim tag, 0 request tag

	// datapath status
	logic cache_hit;
	way_t hit_way;
	logic victim_dirty; // lru way valid and dirty
	way_t lru_way;

	modport ctrl (output way_sel, load_cache, source_sel, load_dirty, load_lru, wb_addr_sel,
		input cache_hit, hit_way, victim_dirty, lru_way);
	modport dp (input way_sel, load_cache, source_sel, load_dirty, load_lru, wb_addr_sel,
		output cache_hit, hit_way, victim_dirty, lru_way);

endinterface : cache_ctrl_if

// ==== hdl/cache_way.sv ====
// one cache way
// valid, dirty, tag and line arrays plus the tag compare
`timescale 1ns/1ps

module cache_way #(
	parameter int SET_BITS = 3
) (
	input  logic                                              clk,
	input  logic                                              rst,
	input  logic [SET_BITS-1:0]                               index,
	input  logic [31-SET_BITS-cache_types_pkg::OFFSET_BITS:0] tag_in,
	input  logic                                              load_line,
	input  logic                                              load_dirty,
	input  logic                                              dirty_in,
	input  cache_types_pkg::line_t                            line_in,
	output logic                                              hit,
	output logic                                              dirty,
	output logic [31-SET_BITS-cache_types_pkg::OFFSET_BITS:0] stored_tag,
	output cache_types_pkg::line_t                            line_out
);
	import cache_types_pkg::*;

	localparam int NUM_SETS = 1 << SET_BITS;
	localparam int TAG_BITS = ADDR_BITS - SET_BITS - OFFSET_BITS;

	logic [NUM_SETS-1:0] valid;      // one per set
	logic [NUM_SETS-1:0] dirty_bits;
	logic [TAG_BITS-1:0] tags [NUM_SETS];
	line_t               lines [NUM_SETS];

	// status bits, cleared on reset
	always_ff @(posedge clk) begin
		if (rst) begin
			valid      <= '0;
			dirty_bits <= '0;
		end else begin
			if (load_line)
				valid[index] <= 1'b1; // any line load makes the entry valid
			if (load_dirty)
				dirty_bits[index] <= dirty_in;
		end
	end

	// tag and data storage
	always_ff @(posedge clk) begin
		if (load_line) begin
			tags[index]  <= tag_in;
			lines[index] <= line_in; // fill or merged write
		end
	end

	assign stored_tag = tags[index];  // victim tag for write back
	assign line_out   = lines[index]; // combinational read
	assign hit        = valid[index] && (tags[index] == tag_in);
	assign dirty      = valid[index] && dirty_bits[index]; // only valid lines need write back

endmodule : cache_way

// ==== hdl/cache_datapath.sv ====
// cache datapath
// two ways, hit select, lru per set, victim choice, write merge and memory address
`timescale 1ns/1ps

module cache_datapath #(
	parameter int SET_BITS = 3
) (
	input  logic                   clk,
	input  logic                   rst,
	input  cache_types_pkg::addr_t mem_address,
	input  cache_types_pkg::word_t mem_wdata,
	input  cache_types_pkg::line_t pmem_rdata,
	input  logic                   mem_write,
	output cache_types_pkg::word_t mem_rdata,
	output cache_types_pkg::addr_t pmem_address,
	output cache_types_pkg::line_t pmem_wdata,
	cache_ctrl_if.dp               bus
);
	import cache_types_pkg::*;

	localparam int NUM_SETS = 1 << SET_BITS;
	localparam int TAG_BITS = ADDR_BITS - SET_BITS - OFFSET_BITS;

	logic [TAG_BITS-1:0] req_tag;
	logic [SET_BITS-1:0] index;
	logic                word_sel;       // which word of the line
	logic [1:0]          way_hit;
	logic [1:0]          way_dirty;
	logic [1:0]          way_load;
	logic [1:0]          way_load_dirty;
	logic [TAG_BITS-1:0] way_tag [2];
	line_t               way_line [2];
	logic [NUM_SETS-1:0] lru_bits;       // way to evict next, per set
	line_t               sel_line;
	line_t               merged_line;
	line_t               fill_line;      // memory line held for the fill cycle
	line_t               line_in;
	logic [TAG_BITS-1:0] line_tag;

	// address split
	assign req_tag  = mem_address[ADDR_BITS-1 -: TAG_BITS];
	assign index    = mem_address[OFFSET_BITS +: SET_BITS];
	assign word_sel = mem_address[WORD_SEL_BIT];

	for (genvar w = 0; w < 2; w++) begin : g_way
		assign way_load[w]       = bus.load_cache && (bus.way_sel == 1'(w));
		assign way_load_dirty[w] = bus.load_dirty && (bus.way_sel == 1'(w));

		cache_way #(.SET_BITS(SET_BITS)) way_inst (
			.clk        (clk),
			.rst        (rst),
			.index      (index),
			.tag_in     (req_tag),
			.load_line  (way_load[w]),
			.load_dirty (way_load_dirty[w]),
			.dirty_in   (mem_write),     // write sets dirty, read fill clears it
			.line_in    (line_in),
			.hit        (way_hit[w]),
			.dirty      (way_dirty[w]),
			.stored_tag (way_tag[w]),
			.line_out   (way_line[w])
		);
	end

	assign bus.cache_hit    = |way_hit;
	assign bus.hit_way      = way_hit[1];      // way 0 unless way 1 matches
	assign bus.lru_way      = lru_bits[index];
	assign bus.victim_dirty = way_dirty[lru_bits[index]];

	// lru bit records the way not touched
	always_ff @(posedge clk) begin
		if (rst)
			lru_bits <= '0;
		else if (bus.load_lru)
			lru_bits[index] <= ~bus.way_sel;
	end

	// capture memory data until the fill cycle uses it
	always_ff @(posedge clk) begin
		if (!bus.source_sel)
			fill_line <= pmem_rdata;
	end

	assign sel_line  = way_line[bus.way_sel];
	assign mem_rdata = sel_line[word_sel*WORD_BITS +: WORD_BITS];

	always_comb begin
		merged_line = sel_line;
		merged_line[word_sel*WORD_BITS +: WORD_BITS] = mem_wdata; // replace the addressed word
	end

	assign line_in      = bus.source_sel ? fill_line : merged_line;
	assign line_tag     = bus.wb_addr_sel ? way_tag[bus.way_sel] : req_tag;
	assign pmem_address = {line_tag, index, {OFFSET_BITS{1'b0}}}; // line aligned
	assign pmem_wdata   = sel_line; // victim line on write back

endmodule : cache_datapath

// ==== hdl/cache_control.sv ====
// cache controller
// write-back miss handling FSM, drives datapath commands and memory strobes
`timescale 1ns/1ps

module cache_control (
	input  logic      clk,
	input  logic      rst,
	input  logic      mem_read,
	input  logic      mem_write,
	input  logic      stall,     // freezes the FSM
	input  logic      pmem_resp,
	output logic      mem_resp,
	output logic      pmem_read,
	output logic      pmem_write,
	cache_ctrl_if.ctrl bus
);
	import cache_ctrl_pkg::*;

	ctrl_state_e state, next_state;
	logic        req;      // cpu request pending
	logic        req_hit;

	assign req     = mem_read | mem_write;
	assign req_hit = req & bus.cache_hit;

	// per-state outputs over defaults
	always_comb begin
		bus.way_sel     = bus.hit_way; // hit way unless handling a miss
		bus.load_cache  = 1'b0;
		bus.source_sel  = 1'b0;
		bus.load_dirty  = 1'b0;
		bus.load_lru    = 1'b0;
		bus.wb_addr_sel = 1'b0;        // request tag
		mem_resp        = 1'b0;
		pmem_read       = 1'b0;
		pmem_write      = 1'b0;

		case (state)
			s_write_back: begin
				bus.way_sel     = bus.lru_way;
				bus.wb_addr_sel = 1'b1; // victim address
				pmem_write      = 1'b1;
			end
			s_load_from_mem: begin
				bus.way_sel = bus.lru_way;
				pmem_read   = 1'b1;
			end
			s_load_into_cache: begin
				bus.way_sel    = bus.lru_way; // replace lru
				bus.load_cache = 1'b1;
				bus.source_sel = 1'b1;        // memory line
				bus.load_dirty = 1'b1;        // 0 on read, 1 on write
			end
			s_respond: begin
				mem_resp       = req_hit; // a new missing request gets no answer here
				bus.load_lru   = req_hit;
				bus.load_cache = req_hit & mem_write; // merge cpu word
				bus.load_dirty = req_hit & mem_write;
			end
			default: ;
		endcase

		// nothing moves while stalled
		if (stall) begin
			mem_resp       = 1'b0;
			pmem_read      = 1'b0;
			pmem_write     = 1'b0;
			bus.load_cache = 1'b0;
			bus.load_dirty = 1'b0;
			bus.load_lru   = 1'b0;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			s_idle, s_respond: begin
				if (req_hit)
					next_state = s_respond; // answer next cycle, or again for back-to-back hits
				else if (req)
					next_state = bus.victim_dirty ? s_write_back : s_load_from_mem;
				else
					next_state = s_idle;
			end
			s_write_back:
				if (pmem_resp) next_state = s_load_from_mem;
			s_load_from_mem:
				if (pmem_resp) next_state = s_load_into_cache;
			s_load_into_cache:
				next_state = s_respond;
			default:
				next_state = s_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= s_idle;
		else if (!stall)
			state <= next_state;
	end

endmodule : cache_control

// ==== hdl/cache_top.sv ====
// two-way set-associative write-back cache
// controller and datapath joined by the command bus
`timescale 1ns/1ps

module cache_top #(
	parameter int SET_BITS = 3 // 8 sets
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   mem_read,
	input  logic                   mem_write,
	input  cache_types_pkg::addr_t mem_address,
	input  cache_types_pkg::word_t mem_wdata,
	output cache_types_pkg::word_t mem_rdata,
	output logic                   mem_resp,
	input  logic                   stall,
	output logic                   pmem_read,
	output logic                   pmem_write,
	output cache_types_pkg::addr_t pmem_address,
	output cache_types_pkg::line_t pmem_wdata,
	input  cache_types_pkg::line_t pmem_rdata,
	input  logic                   pmem_resp
);

	cache_ctrl_if ctrl_bus ();

	cache_control control_inst (
		.clk        (clk),
		.rst        (rst),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.stall      (stall),
		.pmem_resp  (pmem_resp),
		.mem_resp   (mem_resp),
		.pmem_read  (pmem_read),
		.pmem_write (pmem_write),
		.bus        (ctrl_bus.ctrl)
	);

	cache_datapath #(.SET_BITS(SET_BITS)) datapath_inst (
		.clk          (clk),
		.rst          (rst),
		.mem_address  (mem_address),
		.mem_wdata    (mem_wdata),
		.pmem_rdata   (pmem_rdata),
		.mem_write    (mem_write),
		.mem_rdata    (mem_rdata),
		.pmem_address (pmem_address),
		.pmem_wdata   (pmem_wdata),
		.bus          (ctrl_bus.dp)
	);

endmodule : cache_top

// ==== verification/cache_assert.sv ====
// cache controller checks
// memory strobes, response pulses and stall behavior
`timescale 1ns/1ps

module cache_assert (
	input logic                        clk,
	input logic                        rst,
	input logic                        stall,
	input logic                        mem_resp,
	input logic                        pmem_read,
	input logic                        pmem_write,
	input cache_ctrl_pkg::ctrl_state_e state
);
	import cache_ctrl_pkg::*;

	strobe_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(pmem_read && pmem_write)) else $error("pmem_read and pmem_write high together");
	resp_pulse: assert property (@(posedge clk) disable iff (rst)
		mem_resp |=> !mem_resp || (state == s_respond && $past(state) == s_respond))
		else $error("mem_resp held high outside back-to-back responds");
	write_start: assert property (@(posedge clk) disable iff (rst)
		$rose(pmem_write) |-> $past(state) inside {s_idle, s_respond})
		else $error("pmem_write raised from a miss-handling state");
	stall_quiet: assert property (@(posedge clk) disable iff (rst)
		stall |-> !mem_resp) else $error("mem_resp high during stall");

endmodule : cache_assert

bind cache_control cache_assert assert_inst (
	.clk        (clk),
	.rst        (rst),
	.stall      (stall),
	.mem_resp   (mem_resp),
	.pmem_read  (pmem_read),
	.pmem_write (pmem_write),
	.state      (state)
);

// ==== verification/cache_tb.sv ====
// testbench for the two-way write-back cache
// memory model with random latency, requests and expected results from a data file
`timescale 1ns/1ps

module cache_tb;
	import cache_types_pkg::*;

	localparam int    CLK_PERIOD     = 100;
	localparam int    RESET_CYCLES   = 8;
	localparam int    CYCLES_PER_REQ = 40;           // worst miss path is far shorter
	localparam int    MAX_REQS       = 64;
	localparam word_t PAT_HI         = 32'h5a5a_5a5a; // upper word of a fresh line
	localparam word_t PAT_LO         = 32'hc3c3_c3c3; // lower word of a fresh line

	logic   clk = 1'b0;
	logic   rst = 1'b1;
	logic   mem_read = 1'b0;
	logic   mem_write = 1'b0;
	addr_t  mem_address = '0;
	word_t  mem_wdata = '0;
	logic   stall = 1'b0;
	line_t  pmem_rdata = '0;
	logic   pmem_resp = 1'b0;
	word_t  mem_rdata;
	logic   mem_resp, pmem_read, pmem_write;
	addr_t  pmem_address;
	line_t  pmem_wdata;

	logic [103:0] vectors [MAX_REQS]; // op, address, wdata, expected rdata, hit
	line_t        mem_lines [addr_t]; // lines written back by the cache
	line_t        shadow [addr_t];    // cpu view of every written line
	int           num_reqs = 0;
	int           read_count = 0;     // completed pmem reads
	int           write_count = 0;    // completed pmem writes
	int           mem_wait = 0;
	integer       mem_seed = 42;
	integer       stall_seed = 42;

	cache_top #(.SET_BITS(3)) cache_top_inst (.*);

	function automatic line_t initial_line(input addr_t line_addr);
		return {line_addr ^ PAT_HI, line_addr ^ PAT_LO}; // every address bit shows up
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation finished: FAIL");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_value(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
			abort_run($sformatf("mismatch at %0t: %s is %h, expected %h",
				$time, name, actual, expected));
	endtask

	// merge one cpu word into the shadow line
	task automatic record_write(input addr_t addr, input word_t data);
		addr_t line_addr;
		line_t merged;
		line_addr = {addr[31:3], 3'b000};
		merged = shadow.exists(line_addr) ? shadow[line_addr] : initial_line(line_addr);
		if (addr[2])
			merged[63:32] = data;
		else
			merged[31:0] = data;
		shadow[line_addr] = merged;
	endtask

	initial begin
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#1; // request count is known by now
		repeat (RESET_CYCLES + num_reqs * CYCLES_PER_REQ) @(posedge clk);
		abort_run($sformatf("timeout: the cache did not answer all %0d requests", num_reqs));
	end

	// main memory, answers each strobe after 1 to 4 cycles
	always @(posedge clk) begin
		if (rst) begin
			pmem_resp <= 1'b0;
			mem_wait = 0;
		end else if (pmem_resp) begin
			pmem_resp <= 1'b0; // single cycle pulse
		end else if (pmem_read || pmem_write) begin
			if (mem_wait == 0) begin
				mem_wait = 1 + $unsigned($random(mem_seed)) % 4;
			end else if (mem_wait > 1) begin
				mem_wait = mem_wait - 1;
			end else begin
				mem_wait = 0;
				pmem_resp <= 1'b1;
				if (pmem_read) begin
					pmem_rdata <= mem_lines.exists(pmem_address) ?
						mem_lines[pmem_address] : initial_line(pmem_address);
					read_count++;
				end else begin
					if (!shadow.exists(pmem_address))
						abort_run($sformatf("write back of line %h, which the CPU never wrote",
							pmem_address));
					check_value("pmem_wdata", pmem_wdata, shadow[pmem_address]);
					mem_lines[pmem_address] = pmem_wdata;
					write_count++;
				end
			end
		end
	end

	initial begin
		logic [103:0] vec;
		int           reads_before;
		int           writes_before;
		int           stall_len;
		for (int i = 0; i < MAX_REQS; i++)
			vectors[i] = '1; // op f marks an unused entry
		$readmemh("verification/cache_testdata.txt", vectors);
		while (num_reqs < MAX_REQS && vectors[num_reqs][103:100] != 4'hf)
			num_reqs++;
		if (num_reqs == 0)
			abort_run("no requests found in the test data file");
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		for (int r = 0; r < num_reqs; r++) begin
			vec = vectors[r];
			stall_len = $unsigned($random(stall_seed)) % 4; // 0 means no stall
			@(posedge clk);
			mem_read    <= (vec[103:100] == 4'h0);
			mem_write   <= (vec[103:100] == 4'h1);
			mem_address <= vec[99:68];
			mem_wdata   <= vec[67:36];
			stall       <= (stall_len != 0);
			reads_before  = read_count;
			writes_before = write_count;
			if (stall_len != 0) begin
				repeat (stall_len) @(posedge clk);
				stall <= 1'b0;
			end
			@(negedge clk);
			while (!mem_resp)
				@(negedge clk); // mid-cycle, outputs settled
			if (vec[103:100] == 4'h0)
				check_value("mem_rdata", 64'(mem_rdata), 64'(vec[35:4]));
			else
				record_write(vec[99:68], vec[67:36]);
			check_value("hit", 64'(read_count == reads_before), 64'(vec[0]));
			if (vec[0])
				check_value("pmem_write count", 64'(write_count - writes_before), 64'd0);
			else
				check_value("pmem_read count", 64'(read_count - reads_before), 64'd1);
		end
		@(posedge clk);
		mem_read  <= 1'b0;
		mem_write <= 1'b0;
		repeat (2) @(posedge clk);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule : cache_tb

// ==== verification/cache_testdata.txt ====
// op_address_wdata_rdata_hit : op 0 read, 1 write; rdata checked on reads only
// hit 1 means no pmem_read during the request; unused entries read as op f
0_00000100_00000000_c3c3c2c3_0
0_00000104_00000000_5a5a5b5a_1
0_00000100_00000000_c3c3c2c3_1
1_00000104_deadbeef_00000000_1
0_00000104_00000000_deadbeef_1
0_00000100_00000000_c3c3c2c3_1
0_00000200_00000000_c3c3c1c3_0
0_00000304_00000000_5a5a595a_0
0_00000104_00000000_deadbeef_0
0_00001010_00000000_c3c3d3d3_0
0_00002014_00000000_5a5a7a4a_0
0_00001014_00000000_5a5a4a4a_1
1_00003010_0badf00d_00000000_0
0_00001010_00000000_c3c3d3d3_1
0_00002010_00000000_c3c3e3d3_0
0_00003010_00000000_0badf00d_0

// ==== verilog.f ====
hdl/cache_types_pkg.sv
hdl/cache_ctrl_pkg.sv
hdl/cache_ctrl_if.sv
hdl/cache_way.sv
hdl/cache_datapath.sv
hdl/cache_control.sv
hdl/cache_top.sv
verification/cache_assert.sv
verification/cache_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module cache_tb -f verilog.f -o cache_sim; then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/cache_sim; then
	echo "simulation returned a failing status"
	exit 1
fi
exit 0
